// ==== dv/joypad_model.sv ====
`timescale 1ns/10ps

module joypad_model (
    input  logic       i_latch,
    input  logic       i_pad_clk,      // shifts on the rising edge
    input  logic [7:0] i_buttons,      // bit 0 is A, bit 7 is Right
    output logic       o_data
);
    logic [7:0] r_shift = 8'hff;

    // load on latch, then the pad feeds ones once all eight bits are out
    always @(posedge i_pad_clk or posedge i_latch) begin
        if (i_latch)
            r_shift <= i_buttons;
        else
            r_shift <= {1'b1, r_shift[7:1]};
    end

    assign o_data = r_shift[0];

endmodule

// ==== dv/nes_io_tb.sv ====
`timescale 1ns/10ps

module nes_io_tb;
    import nes_pkg::*;

    // about 45 transfers below, none needs more than a few dozen clocks
    localparam int MAX_CYCLES = 20000;

    logic        clk;
    logic        reset;
    logic        awvalid;
    logic        awready;
    cpu_addr_t   awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    axi_resp_t   bresp;
    logic        arvalid;
    logic        arready;
    cpu_addr_t   araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        cs_ram;
    logic        rw_ram;
    cpu_addr_t   address_ram;
    cpu_data_t   data_to_ram;
    cpu_data_t   data_from_ram;
    logic        cs_prg;
    cpu_addr_t   address_prg;
    cpu_data_t   data_prg;
    logic        controller_latch;
    logic        controller_clk;
    logic        controller_1;
    logic        vblank_start;
    logic        nmi_n;
    cpu_data_t   dbg_ctrl;
    cpu_data_t   dbg_mask;
    cpu_data_t   dbg_status;
    cpu_data_t   dbg_scroll_x;
    cpu_data_t   dbg_scroll_y;
    logic        dbg_w;
    cpu_data_t   pad_buttons;
    cpu_data_t   ram_model [2048];
    logic        prg_write_pending;
    int          errors;
    int          errors_at_start;
    int          tests;
    int          cycles = 0;

    nes_io dut_i (
        .i_clk(clk), .i_reset(reset),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
        .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
        .o_cs_ram(cs_ram), .o_rw_ram(rw_ram), .o_address_ram(address_ram),
        .o_data_ram(data_to_ram), .i_data_ram(data_from_ram),
        .o_cs_prg(cs_prg), .o_address_prg(address_prg), .i_data_prg(data_prg),
        .o_controller_latch(controller_latch), .o_controller_clk(controller_clk),
        .i_controller_1(controller_1),
        .i_vblank_start(vblank_start), .o_nmi_n(nmi_n),
        .o_ppu_debug_ppuctrl(dbg_ctrl), .o_ppu_debug_ppumask(dbg_mask),
        .o_ppu_debug_ppustatus(dbg_status), .o_ppu_debug_ppuscroll_x(dbg_scroll_x),
        .o_ppu_debug_ppuscroll_y(dbg_scroll_y), .o_ppu_debug_w(dbg_w)
    );

    joypad_model pad_i (
        .i_latch(controller_latch), .i_pad_clk(controller_clk),
        .i_buttons(pad_buttons), .o_data(controller_1)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////
    // external memories
    //////////////////////////////

    always @(posedge clk) begin
        if (cs_ram) begin
            if (rw_ram)
                data_from_ram <= ram_model[address_ram[10:0]];
            else
                ram_model[address_ram[10:0]] <= data_to_ram;
        end
    end

    // rom byte is low address byte xor high address byte
    always @(posedge clk) begin
        if (cs_prg)
            data_prg <= address_prg[7:0] ^ address_prg[15:8];
    end

    //////////////////////////////
    // error reporting
    //////////////////////////////

    function automatic void log_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endfunction

    function automatic void flag_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endfunction

    task automatic report_test(input string name);
        tests++;
        $display("test %-15s %s, %0d error(s)", name,
                 (errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
        errors_at_start = errors;
    endtask

    //////////////////////////////
    // bus checks
    //////////////////////////////

    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else log_mismatch("B response dropped or changed before BREADY");
    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else log_mismatch("R response dropped or changed before RREADY");
    a_rdata_byte0: assert property (@(posedge clk) disable iff (reset)
        rvalid |-> rdata[31:8] == 24'h0)
        else log_mismatch("read data not zero-extended");
    a_aw_w_together: assert property (@(posedge clk) disable iff (reset)
        awready == wready)
        else log_mismatch("AWREADY and WREADY differ");
    a_ram_11bit: assert property (@(posedge clk) disable iff (reset)
        cs_ram |-> address_ram[15:11] == 5'h00)
        else log_mismatch("RAM address outside 11 bits");
    a_prg_no_write: assert property (@(posedge clk) disable iff (reset)
        prg_write_pending |-> !cs_prg)
        else log_mismatch("PRG chip select on a write");

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    // all tasks start and end 2 ns after a rising edge
    task automatic axi_write(input cpu_addr_t addr, input cpu_data_t data,
                             output axi_resp_t resp);
        int stall;
        stall   = $urandom_range(0, 3);
        awaddr  = addr;
        wdata   = {24'($urandom), data};     // upper lanes are ignored
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #2;
        bready = 1'b1;
        @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input cpu_addr_t addr, output cpu_data_t data,
                            output axi_resp_t resp);
        int stall;
        stall   = $urandom_range(0, 3);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(negedge clk);
        data = rdata[7:0];
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic check_write(input cpu_addr_t addr, input cpu_data_t data,
                               input axi_resp_t exp_resp);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        assert (resp == exp_resp)
            else log_mismatch($sformatf("write %h got resp %0d, expected %0d",
                                        addr, resp, exp_resp));
    endtask

    task automatic check_read(input cpu_addr_t addr, input cpu_data_t exp_data,
                              input axi_resp_t exp_resp);
        cpu_data_t data;
        axi_resp_t resp;
        axi_read(addr, data, resp);
        assert (data == exp_data && resp == exp_resp)
            else log_mismatch($sformatf("read %h got %h resp %0d, expected %h resp %0d",
                                        addr, data, resp, exp_data, exp_resp));
    endtask

    task automatic pulse_vblank();
        vblank_start = 1'b1;
        @(posedge clk);
        #2;
        vblank_start = 1'b0;
    endtask

    task automatic check_idle_outputs(input string when_str);
        assert (!awready && !wready && !arready && !bvalid && !rvalid)
            else log_mismatch({"AXI ready or valid high ", when_str});
        assert (!cs_ram && !cs_prg)
            else log_mismatch({"chip select high ", when_str});
        assert (controller_clk && !controller_latch && nmi_n)
            else log_mismatch({"controller or NMI not idle ", when_str});
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        cpu_data_t d;
        cpu_data_t ctrl;
        cpu_data_t mask_byte;
        cpu_data_t sx;
        cpu_data_t sy;
        cpu_addr_t a;
        cpu_data_t bp_data [$];
        int        i;
        int        accepted;
        int        waited;
        int        got;
        logic      pending;

        void'($urandom(39254));
        $timeformat(-9, 0, " ns", 0);
        for (i = 0; i < 2048; i++)
            ram_model[i] = 8'(i ^ (i >> 3) ^ (i >> 8));

        reset             = 1'b1;
        awvalid           = 1'b0;
        awaddr            = '0;
        wvalid            = 1'b0;
        wdata             = '0;
        bready            = 1'b0;
        arvalid           = 1'b0;
        araddr            = '0;
        rready            = 1'b0;
        data_from_ram     = '0;
        data_prg          = '0;
        vblank_start      = 1'b0;
        pad_buttons       = '0;
        prg_write_pending = 1'b0;
        errors            = 0;
        errors_at_start   = 0;
        tests             = 0;

        // reset held over three rising edges
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
        @(posedge clk);
        #2;
        report_test("reset_state");

        d = 8'($urandom);
        check_write(16'h0123, d, AXI_OKAY);
        check_read(16'h0923, d, AXI_OKAY);
        check_read(16'h1923, d, AXI_OKAY);
        report_test("ram_mirror");

        repeat (4) begin
            a = 16'h8000 | 16'($urandom);
            check_read(a, a[7:0] ^ a[15:8], AXI_OKAY);
        end
        prg_write_pending = 1'b1;
        check_write(16'h8000 | 16'($urandom), 8'($urandom), AXI_SLVERR);
        prg_write_pending = 1'b0;
        check_read(16'h5000, 8'h00, AXI_DECERR);
        report_test("prg_and_errors");

        mask_byte = 8'($urandom);
        check_write(16'h2001, mask_byte, AXI_OKAY);
        assert (dbg_mask == mask_byte)
            else log_mismatch($sformatf("PPUMASK %h, expected %h", dbg_mask, mask_byte));
        ctrl = 8'h80 | 8'($urandom);
        check_write(16'h2000, ctrl, AXI_OKAY);
        assert (dbg_ctrl == ctrl && nmi_n)
            else log_mismatch("PPUCTRL not loaded, or NMI before vblank");
        pulse_vblank();
        @(negedge clk);
        assert (!nmi_n && dbg_status == 8'h80)
            else log_mismatch("NMI or vblank flag not set after vblank start");
        @(posedge clk);
        #2;
        check_read(16'h2002, {1'b1, ctrl[6:0]}, AXI_OKAY);
        assert (nmi_n && dbg_status == 8'h00)
            else log_mismatch("NMI or vblank flag still set after PPUSTATUS read");
        check_read(16'h2002, {1'b0, ctrl[6:0]}, AXI_OKAY);
        sx = 8'($urandom);
        sy = 8'($urandom);
        check_write(16'h3ffd, sx, AXI_OKAY);        // mirror of 2005
        assert (dbg_w) else log_mismatch("write toggle not set after first scroll write");
        check_write(16'h3ffd, sy, AXI_OKAY);
        assert (dbg_scroll_x == sx && dbg_scroll_y == sy && !dbg_w)
            else log_mismatch($sformatf("scroll x %h y %h w %b, expected %h %h 0",
                                        dbg_scroll_x, dbg_scroll_y, dbg_w, sx, sy));
        check_read(16'h2000, sy, AXI_OKAY);         // open bus
        report_test("ppu_registers");

        pad_buttons = 8'($urandom);
        check_write(ADDRESS_JOY1, 8'h01, AXI_OKAY);
        assert (controller_latch) else log_mismatch("controller latch not set");
        check_write(ADDRESS_JOY1, 8'h00, AXI_OKAY);
        assert (!controller_latch) else log_mismatch("controller latch not cleared");
        for (i = 0; i < 8; i++)
            check_read(ADDRESS_JOY1, CONTROLLER_OPEN_BUS | {7'b0, pad_buttons[i]}, AXI_OKAY);
        check_read(ADDRESS_JOY1, CONTROLLER_OPEN_BUS | 8'h01, AXI_OKAY);
        report_test("controller");

        // fill the B hold, then the FIFO, until AWREADY stays low
        accepted = 0;
        waited   = 0;
        d        = 8'($urandom);
        awaddr   = 16'h0200;
        wdata    = {24'h0, d};
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        while (waited < 12 && accepted < 8) begin
            @(negedge clk);
            if (awready) begin
                bp_data.push_back(d);
                accepted++;
                waited = 0;
                d = 8'($urandom);
            end else begin
                waited++;
            end
            @(posedge clk);
            #2;
            awaddr = 16'h0200 + 16'(accepted);
            wdata  = {24'h0, d};
        end
        assert (waited == 12)
            else flag_failure("AWREADY never dropped while BREADY was held low");
        bp_data.push_back(d);                       // still waiting on the AW channel
        pending = 1'b1;
        got     = 0;
        while (got < accepted + 1) begin
            bready = 1'($urandom);
            @(negedge clk);
            if (bvalid && bready) begin
                assert (bresp == AXI_OKAY)
                    else log_mismatch($sformatf("write %0d resp %0d", got, bresp));
                got++;
            end
            if (pending && awready)
                pending = 1'b0;
            @(posedge clk);
            #2;
            if (!pending) begin
                awvalid = 1'b0;
                wvalid  = 1'b0;
            end
        end
        bready = 1'b0;
        for (i = 0; i < bp_data.size(); i++)
            check_read(16'h0200 + 16'(i), bp_data[i], AXI_OKAY);
        report_test("back_pressure");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/nes_pkg.sv
verilog/cpu_bus_bridge.sv
verilog/cpu_request_fifo.sv
verilog/cpu_memory_map.sv
verilog/ppu_register_file.sv
verilog/nes_io.sv
dv/joypad_model.sv
dv/nes_io_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the nes_io testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module nes_io_tb -o nes_io_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/nes_io_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== verilog/cpu_bus_bridge.sv ====
`timescale 1ns/10ps

module cpu_bus_bridge (
    input  logic                i_clk,
    input  logic                i_reset,

    // write address / data
    input  logic                i_awvalid,
    output logic                o_awready,
    input  nes_pkg::cpu_addr_t  i_awaddr,
    input  logic                i_wvalid,
    output logic                o_wready,
    input  logic [31:0]         i_wdata,

    // write response
    output logic                o_bvalid,
    input  logic                i_bready,
    output nes_pkg::axi_resp_t  o_bresp,

    // read address / data
    input  logic                i_arvalid,
    output logic                o_arready,
    input  nes_pkg::cpu_addr_t  i_araddr,
    output logic                o_rvalid,
    input  logic                i_rready,
    output logic [31:0]         o_rdata,
    output nes_pkg::axi_resp_t  o_rresp,

    // request fifo
    output logic                o_req_push,
    output nes_pkg::cpu_req_t   o_req,
    input  logic                i_req_full,

    // responses from the memory map
    input  logic                i_resp_valid,
    input  nes_pkg::cpu_resp_t  i_resp,
    output logic                o_resp_ready
);
    import nes_pkg::*;

    logic      w_write_fire;
    logic      w_read_fire;

    logic      r_bvalid;
    axi_resp_t r_bresp;
    logic      r_rvalid;
    cpu_data_t r_rdata;
    axi_resp_t r_rresp;

    // aw and w are taken together, a write beats a read in the same cycle
    assign w_write_fire = i_awvalid && i_wvalid && !i_req_full;
    assign w_read_fire  = i_arvalid && !(i_awvalid && i_wvalid) && !i_req_full;

    assign o_awready  = w_write_fire;
    assign o_wready   = w_write_fire;
    assign o_arready  = w_read_fire;
    assign o_req_push = w_write_fire || w_read_fire;

    always_comb begin
        o_req.write = w_write_fire;
        o_req.addr  = w_write_fire ? i_awaddr : i_araddr;
        o_req.wdata = w_write_fire ? i_wdata[7:0] : 8'h00;  // byte lane 0 only
    end

    //////////////////////////////
    // response hold registers
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_bvalid <= 1'b0;
            r_rvalid <= 1'b0;
        end else begin
            if (r_bvalid && i_bready)
                r_bvalid <= 1'b0;
            if (r_rvalid && i_rready)
                r_rvalid <= 1'b0;
            if (i_resp_valid && i_resp.write)
                r_bvalid <= 1'b1;
            if (i_resp_valid && !i_resp.write)
                r_rvalid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resp_valid && i_resp.write)
            r_bresp <= i_resp.resp;
        if (i_resp_valid && !i_resp.write) begin
            r_rdata <= i_resp.rdata;
            r_rresp <= i_resp.resp;
        end
    end

    // map may only start an access while both holds are free
    assign o_resp_ready = !r_bvalid && !r_rvalid;

    assign o_bvalid = r_bvalid;
    assign o_bresp  = r_bresp;
    assign o_rvalid = r_rvalid;
    assign o_rdata  = {24'h000000, r_rdata};
    assign o_rresp  = r_rresp;

    // the map checked o_resp_ready two clocks back, nothing can fill a hold since
    a_resp_has_room: assert property (@(posedge i_clk) disable iff (i_reset)
        i_resp_valid |-> o_resp_ready);

endmodule

// ==== verilog/cpu_memory_map.sv ====
`timescale 1ns/10ps

module cpu_memory_map (
    input  logic                  i_clk,
    input  logic                  i_reset,

    // request fifo
    input  logic                  i_req_empty,
    input  nes_pkg::cpu_req_t     i_req,
    output logic                  o_req_pop,

    // response to the bridge
    output logic                  o_resp_valid,
    output nes_pkg::cpu_resp_t    o_resp,
    input  logic                  i_resp_ready,

    // RAM (read / write)
    output logic                  o_cs_ram,
    output logic                  o_rw_ram,         // high for read
    output nes_pkg::cpu_addr_t    o_address_ram,
    output nes_pkg::cpu_data_t    o_data_ram,
    input  nes_pkg::cpu_data_t    i_data_ram,

    // PRG (read only)
    output logic                  o_cs_prg,
    output nes_pkg::cpu_addr_t    o_address_prg,
    input  nes_pkg::cpu_data_t    i_data_prg,

    // PPU registers
    output nes_pkg::ppu_access_t  o_ppu,
    input  nes_pkg::cpu_data_t    i_ppu_data,

    // controller port 1
    output logic                  o_controller_latch,
    output logic                  o_controller_clk,
    input  logic                  i_controller_1
);
    import nes_pkg::*;

    typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_t;

    state_t                               r_state;
    logic [$clog2(CPU_CE_DIVIDE)-1:0]     r_ce_count;
    cpu_req_t                             r_req;
    cpu_data_t                            r_rdata;     // ppu / pad / zero read data
    logic                                 r_latch;

    logic w_tick;
    logic w_access;
    logic w_hit_ram;
    logic w_hit_ppu;
    logic w_hit_joy;
    logic w_hit_prg;

    //////////////////////////////
    // cpu clock enable
    //////////////////////////////

    assign w_tick = (r_ce_count == CPU_CE_DIVIDE - 1);

    always_ff @(posedge i_clk) begin
        if (i_reset)
            r_ce_count <= '0;
        else
            r_ce_count <= w_tick ? '0 : r_ce_count + 1'b1;
    end

    //////////////////////////////
    // access sequencing
    //////////////////////////////

    assign o_req_pop = (r_state == IDLE) && w_tick && !i_req_empty && i_resp_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_state <= IDLE;
            r_latch <= 1'b0;
        end else begin
            case (r_state)
                IDLE:    if (o_req_pop) r_state <= ACCESS;
                ACCESS:  r_state <= RESPOND;
                default: r_state <= IDLE;
            endcase
            if (w_access && w_hit_joy && r_req.write)
                r_latch <= r_req.wdata[0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_req_pop)
            r_req <= i_req;
        // ppu and pad values are only good during the access clock
        if (w_access)
            r_rdata <= w_hit_ppu ? i_ppu_data
                     : w_hit_joy ? (CONTROLLER_OPEN_BUS | {7'b0, i_controller_1})
                     : 8'h00;
    end

    // region decode of the held request
    assign w_access  = (r_state == ACCESS);
    assign w_hit_ram = (r_req.addr[15:13] == 3'b000);
    assign w_hit_ppu = (r_req.addr[15:13] == 3'b001);
    assign w_hit_joy = (r_req.addr == ADDRESS_JOY1);
    assign w_hit_prg = r_req.addr[15];

    assign o_cs_ram      = w_access && w_hit_ram;
    assign o_rw_ram      = !r_req.write;
    assign o_address_ram = r_req.addr & RAM_ADDR_MASK;       // 2 KB mirrored
    assign o_data_ram    = r_req.wdata;

    assign o_cs_prg      = w_access && w_hit_prg && !r_req.write;   // rom, no write strobe
    assign o_address_prg = r_req.addr;

    assign o_ppu.valid = w_access && w_hit_ppu;
    assign o_ppu.rs    = r_req.addr[2:0];
    assign o_ppu.write = r_req.write;
    assign o_ppu.data  = r_req.wdata;

    assign o_controller_latch = r_latch;
    assign o_controller_clk   = !(w_access && w_hit_joy && !r_req.write);

    //////////////////////////////
    // response
    //////////////////////////////

    assign o_resp_valid = (r_state == RESPOND);
    assign o_resp.write = r_req.write;

    always_comb begin
        o_resp.rdata = 8'h00;
        if (!r_req.write)
            o_resp.rdata = w_hit_ram ? i_data_ram
                         : w_hit_prg ? i_data_prg
                         : r_rdata;
        if (w_hit_ram || w_hit_ppu || w_hit_joy)
            o_resp.resp = AXI_OKAY;
        else if (w_hit_prg)
            o_resp.resp = r_req.write ? AXI_SLVERR : AXI_OKAY;
        else
            o_resp.resp = AXI_DECERR;
    end

    a_ram_in_mirror: assert property (@(posedge i_clk) disable iff (i_reset)
        o_cs_ram |-> (o_address_ram <= RAM_ADDR_MASK));

endmodule

// ==== verilog/cpu_request_fifo.sv ====
`timescale 1ns/10ps

module cpu_request_fifo #(
    parameter int DEPTH = nes_pkg::REQ_FIFO_DEPTH
) (
    input  logic               i_clk,
    input  logic               i_reset,

    input  logic               i_push,
    input  nes_pkg::cpu_req_t  i_req,
    output logic               o_full,

    input  logic               i_pop,
    output nes_pkg::cpu_req_t  o_head,
    output logic               o_empty
);
    import nes_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cpu_req_t           r_mem [DEPTH];
    logic [PTR_W-1:0]   r_wr_ptr;
    logic [PTR_W-1:0]   r_rd_ptr;
    logic [CNT_W-1:0]   r_count;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_push)
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            if (i_pop)
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            if (i_push && !i_pop)
                r_count <= r_count + 1'b1;
            else if (i_pop && !i_push)
                r_count <= r_count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push)
            r_mem[r_wr_ptr] <= i_req;
    end

    assign o_head  = r_mem[r_rd_ptr];
    assign o_full  = (r_count == CNT_W'(DEPTH));
    assign o_empty = (r_count == '0);

    // bridge and map must respect the flags
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_push |-> !o_full);
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> !o_empty);

endmodule

// ==== verilog/nes_io.sv ====
`timescale 1ns/10ps

module nes_io (
    input  logic                i_clk,
    input  logic                i_reset,

    // AXI4-Lite slave
    input  logic                i_awvalid,
    output logic                o_awready,
    input  nes_pkg::cpu_addr_t  i_awaddr,
    input  logic                i_wvalid,
    output logic                o_wready,
    input  logic [31:0]         i_wdata,
    output logic                o_bvalid,
    input  logic                i_bready,
    output nes_pkg::axi_resp_t  o_bresp,
    input  logic                i_arvalid,
    output logic                o_arready,
    input  nes_pkg::cpu_addr_t  i_araddr,
    output logic                o_rvalid,
    input  logic                i_rready,
    output logic [31:0]         o_rdata,
    output nes_pkg::axi_resp_t  o_rresp,

    // RAM and PRG
    output logic                o_cs_ram,
    output logic                o_rw_ram,
    output nes_pkg::cpu_addr_t  o_address_ram,
    output nes_pkg::cpu_data_t  o_data_ram,
    input  nes_pkg::cpu_data_t  i_data_ram,
    output logic                o_cs_prg,
    output nes_pkg::cpu_addr_t  o_address_prg,
    input  nes_pkg::cpu_data_t  i_data_prg,

    // controller
    output logic                o_controller_latch,
    output logic                o_controller_clk,
    input  logic                i_controller_1,

    // ppu
    input  logic                i_vblank_start,
    output logic                o_nmi_n,
    output nes_pkg::cpu_data_t  o_ppu_debug_ppuctrl,
    output nes_pkg::cpu_data_t  o_ppu_debug_ppumask,
    output nes_pkg::cpu_data_t  o_ppu_debug_ppustatus,
    output nes_pkg::cpu_data_t  o_ppu_debug_ppuscroll_x,
    output nes_pkg::cpu_data_t  o_ppu_debug_ppuscroll_y,
    output logic                o_ppu_debug_w
);
    import nes_pkg::*;

    logic        w_req_push;
    cpu_req_t    w_req_in;
    logic        w_req_full;
    logic        w_req_pop;
    cpu_req_t    w_req_head;
    logic        w_req_empty;
    logic        w_resp_valid;
    cpu_resp_t   w_resp;
    logic        w_resp_ready;
    ppu_access_t w_ppu;
    cpu_data_t   w_ppu_data;

    cpu_bus_bridge bridge_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
        .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
        .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
        .o_req_push(w_req_push), .o_req(w_req_in), .i_req_full(w_req_full),
        .i_resp_valid(w_resp_valid), .i_resp(w_resp), .o_resp_ready(w_resp_ready)
    );

    cpu_request_fifo #(.DEPTH(REQ_FIFO_DEPTH)) fifo_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(w_req_push), .i_req(w_req_in), .o_full(w_req_full),
        .i_pop(w_req_pop), .o_head(w_req_head), .o_empty(w_req_empty)
    );

    cpu_memory_map map_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_req_empty(w_req_empty), .i_req(w_req_head), .o_req_pop(w_req_pop),
        .o_resp_valid(w_resp_valid), .o_resp(w_resp), .i_resp_ready(w_resp_ready),
        .o_cs_ram(o_cs_ram), .o_rw_ram(o_rw_ram), .o_address_ram(o_address_ram),
        .o_data_ram(o_data_ram), .i_data_ram(i_data_ram),
        .o_cs_prg(o_cs_prg), .o_address_prg(o_address_prg), .i_data_prg(i_data_prg),
        .o_ppu(w_ppu), .i_ppu_data(w_ppu_data),
        .o_controller_latch(o_controller_latch), .o_controller_clk(o_controller_clk),
        .i_controller_1(i_controller_1)
    );

    ppu_register_file ppu_regs_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_ppu(w_ppu), .o_data(w_ppu_data),
        .i_vblank_start(i_vblank_start), .o_nmi_n(o_nmi_n),
        .o_debug_ppuctrl(o_ppu_debug_ppuctrl),
        .o_debug_ppumask(o_ppu_debug_ppumask),
        .o_debug_ppustatus(o_ppu_debug_ppustatus),
        .o_debug_ppuscroll_x(o_ppu_debug_ppuscroll_x),
        .o_debug_ppuscroll_y(o_ppu_debug_ppuscroll_y),
        .o_debug_w(o_ppu_debug_w)
    );

endmodule

// ==== verilog/nes_pkg.sv ====
package nes_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [2:0]  ppu_rs_t;
    typedef logic [1:0]  axi_resp_t;

    // one cpu access, queued between bridge and map
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t wdata;
        logic      write;
    } cpu_req_t;

    typedef struct packed {
        cpu_data_t rdata;
        axi_resp_t resp;
        logic      write;               // routes to B or R
    } cpu_resp_t;

    typedef struct packed {
        logic      valid;
        ppu_rs_t   rs;
        logic      write;
        cpu_data_t data;
    } ppu_access_t;

    //////////////////////////////
    // constants
    //////////////////////////////

    localparam int CPU_CE_DIVIDE  = 3;  // system clocks per cpu cycle
    localparam int REQ_FIFO_DEPTH = 4;

    localparam cpu_addr_t RAM_ADDR_MASK       = 16'h07ff;
    localparam cpu_addr_t ADDRESS_JOY1        = 16'h4016;
    localparam cpu_data_t CONTROLLER_OPEN_BUS = 8'h40;

    localparam axi_resp_t AXI_OKAY   = 2'b00;
    localparam axi_resp_t AXI_SLVERR = 2'b10;
    localparam axi_resp_t AXI_DECERR = 2'b11;

    localparam ppu_rs_t REG_PPUCTRL   = 3'd0;
    localparam ppu_rs_t REG_PPUMASK   = 3'd1;
    localparam ppu_rs_t REG_PPUSTATUS = 3'd2;
    localparam ppu_rs_t REG_PPUSCROLL = 3'd5;

endpackage

// ==== verilog/ppu_register_file.sv ====
`timescale 1ns/10ps

module ppu_register_file (
    input  logic                  i_clk,
    input  logic                  i_reset,

    input  nes_pkg::ppu_access_t  i_ppu,
    output nes_pkg::cpu_data_t    o_data,

    input  logic                  i_vblank_start,   // one clock pulse
    output logic                  o_nmi_n,

    output nes_pkg::cpu_data_t    o_debug_ppuctrl,
    output nes_pkg::cpu_data_t    o_debug_ppumask,
    output nes_pkg::cpu_data_t    o_debug_ppustatus,
    output nes_pkg::cpu_data_t    o_debug_ppuscroll_x,
    output nes_pkg::cpu_data_t    o_debug_ppuscroll_y,
    output logic                  o_debug_w
);
    import nes_pkg::*;

    cpu_data_t r_ppuctrl;
    cpu_data_t r_ppumask;
    cpu_data_t r_scroll_x;
    cpu_data_t r_scroll_y;
    cpu_data_t r_open_bus;     // last value driven onto the ppu data bus
    logic      r_vblank;
    logic      r_w;            // shared first / second write toggle

    logic w_write;
    logic w_status_read;

    assign w_write       = i_ppu.valid && i_ppu.write;
    assign w_status_read = i_ppu.valid && !i_ppu.write && (i_ppu.rs == REG_PPUSTATUS);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_ppuctrl  <= 8'h00;
            r_ppumask  <= 8'h00;
            r_scroll_x <= 8'h00;
            r_scroll_y <= 8'h00;
            r_open_bus <= 8'h00;
            r_vblank   <= 1'b0;
            r_w        <= 1'b0;
        end else begin
            if (w_write) begin
                r_open_bus <= i_ppu.data;
                case (i_ppu.rs)
                    REG_PPUCTRL: r_ppuctrl <= i_ppu.data;
                    REG_PPUMASK: r_ppumask <= i_ppu.data;
                    REG_PPUSCROLL: begin
                        if (r_w)
                            r_scroll_y <= i_ppu.data;
                        else
                            r_scroll_x <= i_ppu.data;
                        r_w <= !r_w;
                    end
                    default: ;                  // read only or not modelled
                endcase
            end
            if (w_status_read) begin
                r_vblank <= 1'b0;
                r_w      <= 1'b0;
            end
            if (i_vblank_start)
                r_vblank <= 1'b1;               // new frame beats a racing status read
        end
    end

    // only status drives real bits, the rest reads back the bus latch
    assign o_data = (i_ppu.rs == REG_PPUSTATUS) ? {r_vblank, r_open_bus[6:0]} : r_open_bus;

    assign o_nmi_n = !(r_vblank && r_ppuctrl[7]);

    assign o_debug_ppuctrl     = r_ppuctrl;
    assign o_debug_ppumask     = r_ppumask;
    assign o_debug_ppustatus   = {r_vblank, 7'b0000000};
    assign o_debug_ppuscroll_x = r_scroll_x;
    assign o_debug_ppuscroll_y = r_scroll_y;
    assign o_debug_w           = r_w;

endmodule
